//--- rtl/ddr_pkg.sv
////////////////////////////////////////
// Widths, RAM size, AXI response codes
// and FSM state types shared by the DDR
// path. Modules import it by wildcard.
////////////////////////////////////////

package ddr_pkg;

   // Bus widths, as on the board top DDR port
   localparam int ADDR_WIDTH = 30;
   localparam int DATA_WIDTH = 32;
   localparam int SEL_WIDTH  = DATA_WIDTH / 8;

   // On-chip RAM size in 32-bit words
   localparam int RAM_WORDS     = 256;
   localparam int RAM_IDX_WIDTH = $clog2(RAM_WORDS);

   typedef logic [ADDR_WIDTH-1:0] addr_t;
   typedef logic [DATA_WIDTH-1:0] data_t;
   typedef logic [SEL_WIDTH-1:0]  sel_t;
   typedef logic [1:0]            resp_t;

   // Only responses the RAM ever gives
   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_DECERR = 2'b11;

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_SEND,
      WR_RESP
   } wr_state_e;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_ADDR,
      RD_DATA
   } rd_state_e;

endpackage

//--- rtl/wb_axi_front.sv
////////////////////////////////////////
// Wishbone classic slave front end.
// Dispatches one transfer at a time to
// the write or read engine and turns the
// engine result into ack or err.
////////////////////////////////////////

module wb_axi_front import ddr_pkg::*; (
   input  logic  clk,
   input  logic  rst_n_i,

   input  logic  wb_cyc_i,
   input  logic  wb_stb_i,
   input  logic  wb_we_i,
   output logic  wb_ack_o,
   output logic  wb_err_o,
   output data_t wb_dat_o,

   output logic  wr_start_o,
   output logic  rd_start_o,

   input  logic  wr_done_i,
   input  resp_t wr_resp_i,
   input  logic  rd_done_i,
   input  resp_t rd_resp_i,
   input  data_t rd_dat_i
);

   logic  busy;
   logic  req;
   logic  done_any;
   resp_t done_resp;

   // New request only when idle, and never in the ack or err cycle itself
   assign req = wb_cyc_i && wb_stb_i && !busy && !wb_ack_o && !wb_err_o;

   // At most one engine is active, so the two done pulses never overlap
   assign done_any  = wr_done_i || rd_done_i;
   assign done_resp = wr_done_i ? wr_resp_i : rd_resp_i;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy       <= 1'b0;
         wr_start_o <= 1'b0;
         rd_start_o <= 1'b0;
         wb_ack_o   <= 1'b0;
         wb_err_o   <= 1'b0;
      end else begin
         wr_start_o <= req && wb_we_i;
         rd_start_o <= req && !wb_we_i;
         wb_ack_o   <= done_any && (done_resp == RESP_OKAY);
         wb_err_o   <= done_any && (done_resp != RESP_OKAY);
         if (req) begin
            busy <= 1'b1;
         end else if (done_any) begin
            busy <= 1'b0;
         end
      end
   end

   // Read data lines up with the ack
   always_ff @(posedge clk) begin
      if (rd_done_i) begin
         wb_dat_o <= rd_dat_i;
      end
   end

   a_ack_err_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(wb_ack_o && wb_err_o));

   // An engine only finishes a transfer that was dispatched
   a_done_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
      (wr_done_i || rd_done_i) |-> busy);

endmodule

//--- rtl/axi_write_ch.sv
////////////////////////////////////////
// AXI4-lite write engine. On start it
// sends one address and one data beat,
// then reports the write response.
////////////////////////////////////////

module axi_write_ch import ddr_pkg::*; (
   input  logic  clk,
   input  logic  rst_n_i,

   input  logic  start_i,
   input  addr_t adr_i,
   input  data_t dat_i,
   input  sel_t  sel_i,
   output logic  done_o,
   output resp_t resp_o,

   output addr_t m_awaddr_o,
   output logic  m_awvalid_o,
   input  logic  m_awready_i,
   output data_t m_wdata_o,
   output sel_t  m_wstrb_o,
   output logic  m_wvalid_o,
   input  logic  m_wready_i,
   input  resp_t m_bresp_i,
   input  logic  m_bvalid_i,
   output logic  m_bready_o
);

   wr_state_e state;
   logic      aw_ok;
   logic      w_ok;

   // Beat is through once its valid is gone or ready is seen
   assign aw_ok = !m_awvalid_o || m_awready_i;
   assign w_ok  = !m_wvalid_o || m_wready_i;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state       <= WR_IDLE;
         m_awvalid_o <= 1'b0;
         m_wvalid_o  <= 1'b0;
         m_bready_o  <= 1'b0;
         done_o      <= 1'b0;
      end else begin
         done_o <= 1'b0;
         case (state)
            WR_IDLE: begin
               if (start_i) begin
                  m_awvalid_o <= 1'b1;
                  m_wvalid_o  <= 1'b1;
                  state       <= WR_SEND;
               end
            end
            WR_SEND: begin
               // Address and data may be taken in either order
               if (m_awready_i) begin
                  m_awvalid_o <= 1'b0;
               end
               if (m_wready_i) begin
                  m_wvalid_o <= 1'b0;
               end
               if (aw_ok && w_ok) begin
                  m_bready_o <= 1'b1;
                  state      <= WR_RESP;
               end
            end
            WR_RESP: begin
               if (m_bvalid_i) begin
                  m_bready_o <= 1'b0;
                  done_o     <= 1'b1;
                  state      <= WR_IDLE;
               end
            end
            default: state <= WR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start_i && state == WR_IDLE) begin
         m_awaddr_o <= adr_i;
         m_wdata_o  <= dat_i;
         m_wstrb_o  <= sel_i;
      end
      if (m_bvalid_i && m_bready_o) begin
         resp_o <= m_bresp_i;
      end
   end

   a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      m_awvalid_o && !m_awready_i |=> m_awvalid_o);

endmodule

//--- rtl/axi_read_ch.sv
////////////////////////////////////////
// AXI4-lite read engine. On start it
// sends one address beat, then returns
// the registered read data and response.
////////////////////////////////////////

module axi_read_ch import ddr_pkg::*; (
   input  logic  clk,
   input  logic  rst_n_i,

   input  logic  start_i,
   input  addr_t adr_i,
   output logic  done_o,
   output resp_t resp_o,
   output data_t dat_o,

   output addr_t m_araddr_o,
   output logic  m_arvalid_o,
   input  logic  m_arready_i,
   input  data_t m_rdata_i,
   input  resp_t m_rresp_i,
   input  logic  m_rvalid_i,
   output logic  m_rready_o
);

   rd_state_e state;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state       <= RD_IDLE;
         m_arvalid_o <= 1'b0;
         m_rready_o  <= 1'b0;
         done_o      <= 1'b0;
      end else begin
         done_o <= 1'b0;
         case (state)
            RD_IDLE: begin
               if (start_i) begin
                  m_arvalid_o <= 1'b1;
                  state       <= RD_ADDR;
               end
            end
            RD_ADDR: begin
               if (m_arready_i) begin
                  m_arvalid_o <= 1'b0;
                  m_rready_o  <= 1'b1;
                  state       <= RD_DATA;
               end
            end
            RD_DATA: begin
               if (m_rvalid_i) begin
                  m_rready_o <= 1'b0;
                  done_o     <= 1'b1;
                  state      <= RD_IDLE;
               end
            end
            default: state <= RD_IDLE;
         endcase
      end
   end

   // Address on start, data and response on the R handshake
   always_ff @(posedge clk) begin
      if (start_i && state == RD_IDLE) begin
         m_araddr_o <= adr_i;
      end
      if (m_rvalid_i && m_rready_o) begin
         dat_o  <= m_rdata_i;
         resp_o <= m_rresp_i;
      end
   end

   a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      m_arvalid_o && !m_arready_i |=> m_arvalid_o);

endmodule

//--- rtl/axi_ram.sv
////////////////////////////////////////
// AXI4-lite slave RAM standing in for
// the DDR controller. Byte strobes on
// writes, decode error out of range.
////////////////////////////////////////

module axi_ram import ddr_pkg::*; (
   input  logic  clk,
   input  logic  rst_n_i,

   input  addr_t s_awaddr_i,
   input  logic  s_awvalid_i,
   output logic  s_awready_o,
   input  data_t s_wdata_i,
   input  sel_t  s_wstrb_i,
   input  logic  s_wvalid_i,
   output logic  s_wready_o,
   output resp_t s_bresp_o,
   output logic  s_bvalid_o,
   input  logic  s_bready_i,

   input  addr_t s_araddr_i,
   input  logic  s_arvalid_i,
   output logic  s_arready_o,
   output data_t s_rdata_o,
   output resp_t s_rresp_o,
   output logic  s_rvalid_o,
   input  logic  s_rready_i
);

   data_t                    mem [RAM_WORDS];
   logic                     wr_fire;
   logic                     rd_fire;
   logic                     wr_hit;
   logic                     rd_hit;
   logic [RAM_IDX_WIDTH-1:0] wr_idx;
   logic [RAM_IDX_WIDTH-1:0] rd_idx;

   // Byte address falls inside the array
   function automatic logic in_range(addr_t a);
      return a[ADDR_WIDTH-1:2] < RAM_WORDS;
   endfunction

   // Address and data are taken together, only with no response pending
   assign s_awready_o = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
   assign s_wready_o  = s_awready_o;
   assign s_arready_o = !s_rvalid_o;

   assign wr_fire = s_awready_o;
   assign rd_fire = s_arvalid_i && s_arready_o;
   assign wr_hit  = in_range(s_awaddr_i);
   assign rd_hit  = in_range(s_araddr_i);
   assign wr_idx  = s_awaddr_i[RAM_IDX_WIDTH+1:2];
   assign rd_idx  = s_araddr_i[RAM_IDX_WIDTH+1:2];

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         s_bvalid_o <= 1'b0;
         s_rvalid_o <= 1'b0;
      end else begin
         if (wr_fire) begin
            s_bvalid_o <= 1'b1;
         end else if (s_bready_i) begin
            s_bvalid_o <= 1'b0;
         end
         if (rd_fire) begin
            s_rvalid_o <= 1'b1;
         end else if (s_rready_i) begin
            s_rvalid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_fire) begin
         s_bresp_o <= wr_hit ? RESP_OKAY : RESP_DECERR;
         if (wr_hit) begin
            for (int i = 0; i < SEL_WIDTH; i++) begin
               if (s_wstrb_i[i]) begin
                  mem[wr_idx][8*i +: 8] <= s_wdata_i[8*i +: 8];
               end
            end
         end
      end
      // Out of range reads give zero data
      if (rd_fire) begin
         s_rresp_o <= rd_hit ? RESP_OKAY : RESP_DECERR;
         s_rdata_o <= rd_hit ? mem[rd_idx] : '0;
      end
   end

   a_b_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));

   a_r_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      s_rvalid_o && !s_rready_i |=>
         s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o));

endmodule

//--- rtl/ddr_subsys.sv
////////////////////////////////////////
// External memory path of the tile top.
// Wishbone classic slave in, bridged to
// AXI4-lite and an on-chip RAM.
////////////////////////////////////////

module ddr_subsys import ddr_pkg::*; (
   input  logic  clk,
   input  logic  rst_n_i,

   input  logic  wb_cyc_i,
   input  logic  wb_stb_i,
   input  logic  wb_we_i,
   input  addr_t wb_adr_i,
   input  data_t wb_dat_i,
   input  sel_t  wb_sel_i,
   output logic  wb_ack_o,
   output logic  wb_err_o,
   output data_t wb_dat_o
);

   // Engine handshakes
   logic  wr_start;
   logic  rd_start;
   logic  wr_done;
   logic  rd_done;
   resp_t wr_resp;
   resp_t rd_resp;
   data_t rd_dat;

   // AXI4-lite write channels
   addr_t awaddr;
   logic  awvalid;
   logic  awready;
   data_t wdata;
   sel_t  wstrb;
   logic  wvalid;
   logic  wready;
   resp_t bresp;
   logic  bvalid;
   logic  bready;

   // AXI4-lite read channels
   addr_t araddr;
   logic  arvalid;
   logic  arready;
   data_t rdata;
   resp_t rresp;
   logic  rvalid;
   logic  rready;

   wb_axi_front u_front (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .wb_cyc_i   (wb_cyc_i),
      .wb_stb_i   (wb_stb_i),
      .wb_we_i    (wb_we_i),
      .wb_ack_o   (wb_ack_o),
      .wb_err_o   (wb_err_o),
      .wb_dat_o   (wb_dat_o),
      .wr_start_o (wr_start),
      .rd_start_o (rd_start),
      .wr_done_i  (wr_done),
      .wr_resp_i  (wr_resp),
      .rd_done_i  (rd_done),
      .rd_resp_i  (rd_resp),
      .rd_dat_i   (rd_dat)
   );

   // Wishbone holds address, data and select until ack
   axi_write_ch u_wr (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .start_i     (wr_start),
      .adr_i       (wb_adr_i),
      .dat_i       (wb_dat_i),
      .sel_i       (wb_sel_i),
      .done_o      (wr_done),
      .resp_o      (wr_resp),
      .m_awaddr_o  (awaddr),
      .m_awvalid_o (awvalid),
      .m_awready_i (awready),
      .m_wdata_o   (wdata),
      .m_wstrb_o   (wstrb),
      .m_wvalid_o  (wvalid),
      .m_wready_i  (wready),
      .m_bresp_i   (bresp),
      .m_bvalid_i  (bvalid),
      .m_bready_o  (bready)
   );

   axi_read_ch u_rd (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .start_i     (rd_start),
      .adr_i       (wb_adr_i),
      .done_o      (rd_done),
      .resp_o      (rd_resp),
      .dat_o       (rd_dat),
      .m_araddr_o  (araddr),
      .m_arvalid_o (arvalid),
      .m_arready_i (arready),
      .m_rdata_i   (rdata),
      .m_rresp_i   (rresp),
      .m_rvalid_i  (rvalid),
      .m_rready_o  (rready)
   );

   axi_ram u_ram (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .s_awaddr_i  (awaddr),
      .s_awvalid_i (awvalid),
      .s_awready_o (awready),
      .s_wdata_i   (wdata),
      .s_wstrb_i   (wstrb),
      .s_wvalid_i  (wvalid),
      .s_wready_o  (wready),
      .s_bresp_o   (bresp),
      .s_bvalid_o  (bvalid),
      .s_bready_i  (bready),
      .s_araddr_i  (araddr),
      .s_arvalid_i (arvalid),
      .s_arready_o (arready),
      .s_rdata_o   (rdata),
      .s_rresp_o   (rresp),
      .s_rvalid_o  (rvalid),
      .s_rready_i  (rready)
   );

endmodule

//--- test/tb_ddr_subsys.sv
////////////////////////////////////////
// Testbench for the DDR subsystem. Runs
// a fixed Wishbone table, then random
// traffic, against a reference memory
// that merges byte lanes like the RAM.
////////////////////////////////////////

module tb_ddr_subsys import ddr_pkg::*; ();

   localparam int CLK_PERIOD     = 100;
   localparam int RST_CYCLES     = 16;
   localparam int TABLE_LEN      = 18;
   localparam int RAND_COUNT     = 64;
   localparam int RAND_WORDS     = 32;
   localparam int LCG_SEED       = 45;
   localparam int WAIT_LIMIT     = 20;
   localparam int MIN_LATENCY    = 4;
   localparam int TIMEOUT_CYCLES = 30 * (TABLE_LEN + RAND_COUNT) + RST_CYCLES;

   typedef struct packed {
      logic  we;
      addr_t adr;
      data_t dat;
      sel_t  sel;
      logic  err;
   } xfer_t;

   logic  clk;
   logic  rst_n_i;
   logic  wb_cyc_i;
   logic  wb_stb_i;
   logic  wb_we_i;
   addr_t wb_adr_i;
   data_t wb_dat_i;
   sel_t  wb_sel_i;
   logic  wb_ack_o;
   logic  wb_err_o;
   data_t wb_dat_o;

   xfer_t       stim [TABLE_LEN];
   data_t       ref_mem [RAM_WORDS];
   logic        ref_vld [RAM_WORDS];
   int unsigned lcg_state;
   int          errors    = 0;
   int          xfers     = 0;
   int          reads     = 0;
   int          resp_seen = 0;
   int          cycles    = 0;
   logic        live_q    = 1'b0;

   ddr_subsys ddr_subsys_i (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_sel_i (wb_sel_i),
      .wb_ack_o (wb_ack_o),
      .wb_err_o (wb_err_o),
      .wb_dat_o (wb_dat_o)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   function automatic int unsigned next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;
   endfunction

   // Request state as the DUT saw it at the last rising edge
   always @(posedge clk) begin
      cycles++;
      live_q = rst_n_i && wb_cyc_i && wb_stb_i;
   end

   always @(negedge clk) begin
      if ((wb_ack_o || wb_err_o) && !live_q) begin
         $display("Failure at %0t: ack or err with no request or in reset", $time);
         errors++;
      end
      if (wb_ack_o || wb_err_o) begin
         resp_seen++;
      end
   end

   // One classic cycle, ended on ack or err; reference memory follows writes
   task automatic run_xfer(input logic we, input addr_t adr, input data_t dat,
                           input sel_t sel, input logic exp_err);
      int   waited;
      int   idx;
      logic got;
      idx      = int'(adr[ADDR_WIDTH-1:2]);
      waited   = 0;
      got      = 1'b0;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = dat;
      wb_sel_i = sel;
      xfers++;
      while (!got && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
         got = wb_ack_o || wb_err_o;
      end
      if (!got) begin
         $display("Missing response at %0t: no ack or err for %s at %h",
                  $time, we ? "write" : "read", adr);
         errors++;
      end else begin
         if (wb_ack_o && wb_err_o) begin
            $display("Failure at %0t: ack and err high together", $time);
            errors++;
         end
         // Earlier than this means a stale or stretched response
         if (waited < MIN_LATENCY) begin
            $display("Failure at %0t: response after only %0d cycles", $time, waited);
            errors++;
         end
         if (wb_err_o !== exp_err) begin
            $display("** Error at %0t: wb_err_o expected %b, got %b",
                     $time, exp_err, wb_err_o);
            errors++;
         end
         if (!we && !exp_err) begin
            reads++;
            if (wb_dat_o !== ref_mem[idx]) begin
               $display("** Error at %0t: wb_dat_o expected %h, got %h",
                        $time, ref_mem[idx], wb_dat_o);
               errors++;
            end
         end
      end
      if (we && idx < RAM_WORDS) begin
         for (int b = 0; b < SEL_WIDTH; b++) begin
            if (sel[b]) begin
               ref_mem[idx][8*b +: 8] = dat[8*b +: 8];
            end
         end
         if (sel == '1) begin
            ref_vld[idx] = 1'b1;
         end
      end
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
   endtask

   initial begin
      wait (cycles >= TIMEOUT_CYCLES);
      $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Transfers %0d, reads checked %0d, errors %0d", xfers, reads, errors + 1);
      $display("** FAIL **");
      $finish;
   end

   initial begin
      int    idx;
      int    gap;
      logic  we;
      data_t dat;
      sel_t  sel;
      lcg_state = LCG_SEED;
      rst_n_i   = 1'b0;
      wb_cyc_i  = 1'b0;
      wb_stb_i  = 1'b0;
      wb_we_i   = 1'b0;
      wb_adr_i  = '0;
      wb_dat_i  = '0;
      wb_sel_i  = '0;
      for (int i = 0; i < RAM_WORDS; i++) begin
         ref_vld[i] = 1'b0;
      end
      // we, address, data, select, expected err
      stim = '{
         '{1'b1, 30'h000, 32'hDEADBEEF, 4'hF, 1'b0},
         '{1'b0, 30'h000, 32'h0,        4'hF, 1'b0},
         '{1'b1, 30'h004, 32'h11223344, 4'hF, 1'b0},
         '{1'b1, 30'h004, 32'hAABBCCDD, 4'h5, 1'b0},
         '{1'b0, 30'h004, 32'h0,        4'hF, 1'b0},
         '{1'b1, 30'h3FC, 32'h01234567, 4'hF, 1'b0},
         '{1'b1, 30'h3FD, 32'hA5000000, 4'h8, 1'b0},
         '{1'b0, 30'h3FC, 32'h0,        4'hF, 1'b0},
         // Out of range, and 0x400 aliases word 0 in the low index bits
         '{1'b1, 30'h400, 32'hFFFFFFFF, 4'hF, 1'b1},
         '{1'b0, 30'h000, 32'h0,        4'hF, 1'b0},
         '{1'b0, 30'h400, 32'h0,        4'hF, 1'b1},
         '{1'b0, 30'h3FFFFFFC, 32'h0,   4'hF, 1'b1},
         // Unaligned writes, aligned reads
         '{1'b1, 30'h009, 32'h0F0F0F0F, 4'hF, 1'b0},
         '{1'b0, 30'h008, 32'h0,        4'hF, 1'b0},
         '{1'b1, 30'h00E, 32'h5A5A5A5A, 4'hF, 1'b0},
         '{1'b0, 30'h00C, 32'h0,        4'hF, 1'b0},
         '{1'b1, 30'h013, 32'hC3C3C3C3, 4'hF, 1'b0},
         '{1'b0, 30'h010, 32'h0,        4'hF, 1'b0}
      };
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n_i = 1'b1;
      @(negedge clk);

      foreach (stim[i]) begin
         run_xfer(stim[i].we, stim[i].adr, stim[i].dat, stim[i].sel, stim[i].err);
         @(negedge clk);
      end

      // Zero gap keeps stb high into the next transfer
      for (int n = 0; n < RAND_COUNT; n++) begin
         we  = (next_rand() % 2) == 1;
         idx = int'(next_rand() % RAND_WORDS);
         dat = (next_rand() << 16) | next_rand();
         sel = sel_t'(next_rand());
         if (!ref_vld[idx]) begin
            we  = 1'b1;
            sel = '1;
         end
         run_xfer(we, addr_t'(idx * 4 + next_rand() % 4), dat, sel, 1'b0);
         gap = int'(next_rand() % 4);
         repeat (gap) @(negedge clk);
      end

      repeat (4) @(negedge clk);
      if (resp_seen != xfers) begin
         $display("Failure: %0d responses seen for %0d transfers", resp_seen, xfers);
         errors++;
      end
      $display("Transfers %0d, reads checked %0d, errors %0d", xfers, reads, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- list.f
rtl/ddr_pkg.sv
rtl/wb_axi_front.sv
rtl/axi_write_ch.sv
rtl/axi_read_ch.sv
rtl/axi_ram.sv
rtl/ddr_subsys.sv
test/tb_ddr_subsys.sv

//--- Bender.yml
package:
  name: ddr_subsys

sources:
  - rtl/ddr_pkg.sv
  - rtl/wb_axi_front.sv
  - rtl/axi_write_ch.sv
  - rtl/axi_read_ch.sv
  - rtl/axi_ram.sv
  - rtl/ddr_subsys.sv
  - target: test
    files:
      - test/tb_ddr_subsys.sv
